/* Bender.yml */
package:
  name: chip_nexus

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - nexus_uart_pkg.sv
      - nexus_ctrl_pkg.sv
      - baud_timer.sv
      - uart_rx.sv
      - uart_tx.sv
      - cmd_fsm.sv
      - nexus_soc.sv
      - chip_nexus.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_chip_nexus.sv

/* baud_timer.sv */
// Shared oversample tick generator built from a reloading down-counter
`default_nettype none

`include "nexus_config.svh"

module baud_timer (
  input  wire logic clk_ibex,
  input  wire logic rst_n,
  output logic      tick_o
);

  // Counter wide enough to hold NEXUS_OVS_DIV - 1, at least one bit
  localparam int unsigned cnt_w = (`NEXUS_OVS_DIV > 1) ? $clog2(`NEXUS_OVS_DIV) : 1;
  localparam logic [cnt_w-1:0] reload = cnt_w'(`NEXUS_OVS_DIV - 1);

  logic [cnt_w-1:0] cnt_q;

  // The tick is registered so all four UART blocks see the same clean pulse
  always_ff @(posedge clk_ibex or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= reload;
      tick_o <= 1'b0;
    end else begin
      if (cnt_q == '0) begin
        // Wrap point, one tick per NEXUS_OVS_DIV cycles
        cnt_q  <= reload;
        tick_o <= 1'b1;
      end else begin
        cnt_q  <= cnt_q - 1'b1;
        tick_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* chip_nexus.sv */
// Chip top with reset synchronizer, pad struct packing and status pad outputs
`default_nettype none

`include "nexus_config.svh"

module chip_nexus (
  input  wire logic                       clk_ibex,
  input  wire logic                       rst_n,
  input  wire logic [`NEXUS_NUM_UART-1:0] rx_i,
  output logic [`NEXUS_NUM_UART-1:0]      tx_o,
  output logic                            io_halted_o,
  output logic                            io_fault_o,
  output logic                            io_halted_n_o,
  output logic                            io_fault_n_o
);

  logic                                                   rst_sync_q;
  logic                                                   rst_ibex_n;
  nexus_uart_pkg::uart_sideband_i_t [`NEXUS_NUM_UART-1:0] uart_sideband_i;
  nexus_uart_pkg::uart_sideband_o_t [`NEXUS_NUM_UART-1:0] uart_sideband_o;
  nexus_ctrl_pkg::status_t                                status;

  // Assert asynchronously, release two clk_ibex edges after rst_n rises
  always_ff @(posedge clk_ibex or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= 1'b0;
      rst_ibex_n <= 1'b0;
    end else begin
      rst_sync_q <= 1'b1;
      rst_ibex_n <= rst_sync_q;
    end
  end

  // Pads map one to one onto the sideband structs
  for (genvar i = 0; i < `NEXUS_NUM_UART; i++) begin : g_pad
    assign uart_sideband_i[i].cio_rx = rx_i[i];
    assign tx_o[i]                   = uart_sideband_o[i].cio_tx;
  end

  nexus_soc u_nexus_soc (
    .clk_ibex        (clk_ibex),
    .rst_n           (rst_ibex_n),
    .uart_sideband_i (uart_sideband_i),
    .uart_sideband_o (uart_sideband_o),
    .status_o        (status)
  );

  // Active-low copies for board indicators
  assign io_halted_o   = status.halted;
  assign io_fault_o    = status.fault;
  assign io_halted_n_o = ~status.halted;
  assign io_fault_n_o  = ~status.fault;

endmodule

`default_nettype wire

/* cmd_fsm.sv */
// Console command FSM with channel 1 bridging, holding registers and status flags
`default_nettype none

module cmd_fsm (
  input  wire logic                         clk_ibex,
  input  wire logic                         rst_n,
  input  wire nexus_uart_pkg::uart_rx_evt_t con_evt_i,
  input  wire nexus_uart_pkg::uart_rx_evt_t brg_evt_i,
  input  wire logic                         con_busy_i,
  input  wire logic                         brg_busy_i,
  output nexus_uart_pkg::uart_tx_req_t      con_req_o,
  output nexus_uart_pkg::uart_tx_req_t      brg_req_o,
  output nexus_ctrl_pkg::status_t           status_o
);

  nexus_ctrl_pkg::ctrl_state_e state_q;
  nexus_ctrl_pkg::ctrl_state_e state_d;
  nexus_ctrl_pkg::status_t     status_q;
  nexus_ctrl_pkg::status_t     status_d;
  nexus_ctrl_pkg::opcode_e     opcode;
  // Destination picked by the opcode that is waiting for its data byte
  logic                        wait_dst_q;
  logic                        wait_dst_d;
  logic                        con_full_q;
  logic                        con_full_d;
  logic                        brg_full_q;
  logic                        brg_full_d;
  logic                        con_load;
  logic                        brg_load;
  // Console holding register and its destination, 0 for echo and 1 for forward
  logic [7:0]                  con_data_q;
  logic                        con_dst_q;
  logic [7:0]                  brg_data_q;
  logic                        con_dst_busy;

  assign opcode       = nexus_ctrl_pkg::opcode_e'(con_evt_i.data);
  assign con_dst_busy = con_dst_q ? brg_busy_i : con_busy_i;

  always_comb begin
    state_d    = state_q;
    status_d   = status_q;
    wait_dst_d = wait_dst_q;
    con_full_d = con_full_q;
    brg_full_d = brg_full_q;
    con_load   = 1'b0;
    brg_load   = 1'b0;

    // Both drain states empty their register in the same cycle as the request
    if (state_q == nexus_ctrl_pkg::ST_SEND) begin
      con_full_d = 1'b0;
    end
    if (state_q == nexus_ctrl_pkg::ST_BRIDGE) begin
      brg_full_d = 1'b0;
    end

    if (state_q == nexus_ctrl_pkg::ST_WAIT_DATA) begin
      // The next console byte is payload and is never decoded
      if (con_evt_i.valid) begin
        state_d = nexus_ctrl_pkg::ST_IDLE;
        if (con_evt_i.frame_err || con_full_q) begin
          status_d.fault = 1'b1;
        end else begin
          con_load   = 1'b1;
          con_full_d = 1'b1;
        end
      end
    end else begin
      // Drains start only from ST_IDLE, console first
      state_d = nexus_ctrl_pkg::ST_IDLE;
      if (state_q == nexus_ctrl_pkg::ST_IDLE) begin
        if (con_full_q && !con_dst_busy) begin
          state_d = nexus_ctrl_pkg::ST_SEND;
        end else if (brg_full_q && !con_busy_i) begin
          state_d = nexus_ctrl_pkg::ST_BRIDGE;
        end
      end
      // Opcode decode, a data-bearing opcode defers any drain by one byte
      if (con_evt_i.valid) begin
        if (con_evt_i.frame_err) begin
          status_d.fault = 1'b1;
        end else if (opcode == nexus_ctrl_pkg::OP_CLR) begin
          status_d = '0;
        end else if (!status_q.halted) begin
          case (opcode)
            nexus_ctrl_pkg::OP_HALT: begin
              status_d.halted = 1'b1;
            end
            nexus_ctrl_pkg::OP_ECHO: begin
              state_d    = nexus_ctrl_pkg::ST_WAIT_DATA;
              wait_dst_d = 1'b0;
            end
            nexus_ctrl_pkg::OP_FWD: begin
              state_d    = nexus_ctrl_pkg::ST_WAIT_DATA;
              wait_dst_d = 1'b1;
            end
            default: begin
              status_d.fault = 1'b1;
            end
          endcase
        end
      end
    end

    // Bridge bytes are taken in any state, and a fault here beats OP_CLR
    if (brg_evt_i.valid) begin
      if (brg_evt_i.frame_err ||
          (brg_full_q && state_q != nexus_ctrl_pkg::ST_BRIDGE)) begin
        status_d.fault = 1'b1;
      end else begin
        brg_load   = 1'b1;
        brg_full_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_ibex or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= nexus_ctrl_pkg::ST_IDLE;
      status_q   <= '0;
      wait_dst_q <= 1'b0;
      con_full_q <= 1'b0;
      brg_full_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      status_q   <= status_d;
      wait_dst_q <= wait_dst_d;
      con_full_q <= con_full_d;
      brg_full_q <= brg_full_d;
    end
  end

  always_ff @(posedge clk_ibex) begin
    if (con_load) begin
      con_data_q <= con_evt_i.data;
      con_dst_q  <= wait_dst_q;
    end
    if (brg_load) begin
      brg_data_q <= brg_evt_i.data;
    end
  end

  // The console transmitter serves echo and bridge traffic, channel 1 only forwards
  always_comb begin
    con_req_o = '0;
    brg_req_o = '0;
    if (state_q == nexus_ctrl_pkg::ST_SEND) begin
      if (con_dst_q) begin
        brg_req_o.valid = 1'b1;
        brg_req_o.data  = con_data_q;
      end else begin
        con_req_o.valid = 1'b1;
        con_req_o.data  = con_data_q;
      end
    end else if (state_q == nexus_ctrl_pkg::ST_BRIDGE) begin
      con_req_o.valid = 1'b1;
      con_req_o.data  = brg_data_q;
    end
  end

  assign status_o = status_q;

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
nexus_uart_pkg.sv
nexus_ctrl_pkg.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
cmd_fsm.sv
nexus_soc.sv
chip_nexus.sv
tb_chip_nexus.sv

/* nexus_config.svh */
// Build-time macros for the oversample divider, oversample rate and channel count
`ifndef NEXUS_CONFIG_SVH
`define NEXUS_CONFIG_SVH

// Number of clk_ibex cycles between two oversample ticks
`define NEXUS_OVS_DIV 4

// Oversample ticks per serial bit, so one bit lasts NEXUS_OVS_DIV * 16 cycles
`define NEXUS_OVS_RATE 16

// Serial channels on the pads
// Channel 0 is the console and channel 1 is the bridged port
`define NEXUS_NUM_UART 2

`endif

/* nexus_ctrl_pkg.sv */
// Console opcode enum, command controller state enum and status struct
`default_nettype none

package nexus_ctrl_pkg;

  // Opcodes accepted on the console channel
  // Any byte outside this list is treated as an unknown opcode
  typedef enum logic [7:0] {
    OP_ECHO = 8'h01,
    OP_FWD  = 8'h02,
    OP_HALT = 8'h03,
    OP_CLR  = 8'h04
  } opcode_e;

  // Command controller states
  // ST_SEND and ST_BRIDGE each last a single cycle and issue one request
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_DATA,
    ST_SEND,
    ST_BRIDGE
  } ctrl_state_e;

  // Sticky status flags reported to the pads
  typedef struct packed {
    logic halted;
    logic fault;
  } status_t;

endpackage

`default_nettype wire

/* nexus_soc.sv */
// Core with the shared baud timer, two UART channels and the command FSM
`default_nettype none

`include "nexus_config.svh"

module nexus_soc (
  input  wire logic                                               clk_ibex,
  input  wire logic                                               rst_n,
  input  wire nexus_uart_pkg::uart_sideband_i_t [`NEXUS_NUM_UART-1:0] uart_sideband_i,
  output nexus_uart_pkg::uart_sideband_o_t [`NEXUS_NUM_UART-1:0]      uart_sideband_o,
  output nexus_ctrl_pkg::status_t                                     status_o
);

  logic                                               tick;
  nexus_uart_pkg::uart_rx_evt_t [`NEXUS_NUM_UART-1:0] rx_evt;
  nexus_uart_pkg::uart_tx_req_t [`NEXUS_NUM_UART-1:0] tx_req;
  logic [`NEXUS_NUM_UART-1:0]                         tx_busy;

  // One time base keeps every receiver and transmitter in phase
  baud_timer u_baud_timer (
    .clk_ibex (clk_ibex),
    .rst_n    (rst_n),
    .tick_o   (tick)
  );

  for (genvar i = 0; i < `NEXUS_NUM_UART; i++) begin : g_uart
    uart_rx u_uart_rx (
      .clk_ibex (clk_ibex),
      .rst_n    (rst_n),
      .tick_i   (tick),
      .rx_i     (uart_sideband_i[i].cio_rx),
      .evt_o    (rx_evt[i])
    );

    uart_tx u_uart_tx (
      .clk_ibex (clk_ibex),
      .rst_n    (rst_n),
      .tick_i   (tick),
      .req_i    (tx_req[i]),
      .tx_o     (uart_sideband_o[i].cio_tx),
      .busy_o   (tx_busy[i])
    );
  end

  // Channel 0 is the console and channel 1 the bridged port
  cmd_fsm u_cmd_fsm (
    .clk_ibex   (clk_ibex),
    .rst_n      (rst_n),
    .con_evt_i  (rx_evt[0]),
    .brg_evt_i  (rx_evt[1]),
    .con_busy_i (tx_busy[0]),
    .brg_busy_i (tx_busy[1]),
    .con_req_o  (tx_req[0]),
    .brg_req_o  (tx_req[1]),
    .status_o   (status_o)
  );

endmodule

`default_nettype wire

/* nexus_uart_pkg.sv */
// UART pad sideband structs, receive event struct and transmit request struct
`default_nettype none

package nexus_uart_pkg;

  // Pad side of one channel, towards the core
  typedef struct packed {
    logic cio_rx;
  } uart_sideband_i_t;

  // Pad side of one channel, away from the core
  typedef struct packed {
    logic cio_tx;
  } uart_sideband_o_t;

  // One received byte, valid for a single cycle
  // frame_err marks a stop bit that was sampled low
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
    logic       frame_err;
  } uart_rx_evt_t;

  // One byte to transmit, valid for a single cycle
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_tx_req_t;

endpackage

`default_nettype wire

/* tb_chip_nexus.sv */
// Testbench for chip_nexus with serial driver, line monitors, reference model and checks
`default_nettype none

`include "nexus_config.svh"

module tb_chip_nexus;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int bit_cycles   = `NEXUS_OVS_DIV * `NEXUS_OVS_RATE;
  localparam int frame_cycles = 10 * bit_cycles;
  // Frame slots of all five behaviors, stimulus plus drain and settle gaps
  localparam int total_frames   = 84;
  localparam int timeout_cycles = total_frames * frame_cycles * 3 / 2;

  logic       clk_ibex;
  logic       rst_n;
  logic [1:0] rx;
  logic [1:0] tx;
  logic       io_halted;
  logic       io_fault;
  logic       io_halted_n;
  logic       io_fault_n;

  // Reference model state, mirrors the console command rules
  nexus_ctrl_pkg::status_t ref_status;
  logic                    ref_wait;
  logic                    ref_dst;

  // Queue entries are {tx channel, byte}
  logic [8:0]  exp_q[$];
  logic [8:0]  got_q[$];
  int          cycles;

  chip_nexus uut (
    .clk_ibex      (clk_ibex),
    .rst_n         (rst_n),
    .rx_i          (rx),
    .tx_o          (tx),
    .io_halted_o   (io_halted),
    .io_fault_o    (io_fault),
    .io_halted_n_o (io_halted_n),
    .io_fault_n_o  (io_fault_n)
  );

  initial begin
    clk_ibex = 1'b0;
    forever #10 clk_ibex = ~clk_ibex;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($urandom);
  endfunction

  // Applies one console byte to the model and returns the tx channel it leaves on, or -1
  function automatic int model_console(input logic [7:0] b, input bit bad_stop);
    int dst;
    dst = -1;
    if (ref_wait) begin
      // Payload byte after ECHO or FWD is never decoded
      ref_wait = 1'b0;
      if (bad_stop) begin
        ref_status.fault = 1'b1;
      end else begin
        dst = int'(ref_dst);
      end
    end else if (bad_stop) begin
      ref_status.fault = 1'b1;
    end else if (b == nexus_ctrl_pkg::OP_CLR) begin
      ref_status = '0;
    end else if (!ref_status.halted) begin
      case (b)
        nexus_ctrl_pkg::OP_HALT: ref_status.halted = 1'b1;
        nexus_ctrl_pkg::OP_ECHO: begin
          ref_wait = 1'b1;
          ref_dst  = 1'b0;
        end
        nexus_ctrl_pkg::OP_FWD: begin
          ref_wait = 1'b1;
          ref_dst  = 1'b1;
        end
        default: ref_status.fault = 1'b1;
      endcase
    end
    return dst;
  endfunction

  // A channel 1 byte reaches tx channel 0 unless it is broken or overruns the register
  function automatic bit model_bridge(input bit bad_stop, input bit overrun);
    if (bad_stop || overrun) begin
      ref_status.fault = 1'b1;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Shifts one 8N1 frame onto rx, a set bad_stop drives the stop bit low
  task automatic send_frame(input int ch, input logic [7:0] data, input bit bad_stop);
    logic [9:0] frame;
    frame = {~bad_stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_ibex);
      rx[ch] <= frame[i];
      repeat (bit_cycles - 1) @(posedge clk_ibex);
    end
    @(posedge clk_ibex);
    rx[ch] <= 1'b1;
  endtask

  task automatic console_byte(input logic [7:0] b, input bit bad_stop);
    int dst;
    dst = model_console(b, bad_stop);
    if (dst >= 0) begin
      exp_q.push_back({dst[0], b});
    end
    send_frame(0, b, bad_stop);
  endtask

  task automatic bridge_byte(input logic [7:0] b, input bit bad_stop, input bit overrun);
    if (model_bridge(bad_stop, overrun)) begin
      exp_q.push_back({1'b0, b});
    end
    send_frame(1, b, bad_stop);
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input bit ch);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0d ns: tx channel %0d sent %02h, expected %02h",
                          $time, ch, got, exp));
    end
  endtask

  task automatic check_status(input nexus_ctrl_pkg::status_t exp);
    nexus_ctrl_pkg::status_t act;
    act.halted = io_halted;
    act.fault  = io_fault;
    if (act !== exp) begin
      abort_run($sformatf("FAIL at %0d ns: halted %b fault %b, expected halted %b fault %b",
                          $time, act.halted, act.fault, exp.halted, exp.fault));
    end
    if (io_halted_n !== ~exp.halted || io_fault_n !== ~exp.fault) begin
      abort_run($sformatf("FAIL at %0d ns: inverted status %b %b, expected %b %b",
                          $time, io_halted_n, io_fault_n, ~exp.halted, ~exp.fault));
    end
  endtask

  // Order on one channel depends on FSM arbitration, so match any pending byte there
  task automatic match_byte(input logic [8:0] got);
    int hit;
    int head;
    hit  = -1;
    head = -1;
    foreach (exp_q[i]) begin
      if (head < 0 && exp_q[i][8] == got[8]) head = i;
      if (hit < 0 && exp_q[i] == got) hit = i;
    end
    if (hit >= 0) begin
      check_byte(got[7:0], exp_q[hit][7:0], got[8]);
      exp_q.delete(hit);
    end else if (head >= 0) begin
      check_byte(got[7:0], exp_q[head][7:0], got[8]);
    end else begin
      abort_run($sformatf("Byte %02h appeared on tx channel %0d when none was expected",
                          got[7:0], got[8]));
    end
  endtask

  // Decodes frames on one tx line, sampling at the middle of each bit
  task automatic decode_line(input bit ch);
    logic [7:0] b;
    forever begin
      @(negedge clk_ibex);
      if (rst_n && tx[ch] === 1'b0) begin
        repeat (bit_cycles / 2) @(negedge clk_ibex);
        for (int i = 0; i < 8; i++) begin
          repeat (bit_cycles) @(negedge clk_ibex);
          b[i] = tx[ch];
        end
        repeat (bit_cycles) @(negedge clk_ibex);
        if (tx[ch] !== 1'b1) begin
          abort_run($sformatf("Stop bit on tx channel %0d was not high", ch));
        end
        got_q.push_back({ch, b});
      end
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_ibex);
  endtask

  // One frame plus two bits, long enough for any stray byte to be decoded
  task automatic settle();
    repeat (frame_cycles + 2 * bit_cycles) @(negedge clk_ibex);
  endtask

  task automatic clear_status();
    console_byte(nexus_ctrl_pkg::OP_CLR, 1'b0);
    settle();
    check_status(ref_status);
  endtask

  initial begin
    decode_line(1'b0);
  end

  initial begin
    decode_line(1'b1);
  end

  initial begin : compare_bytes
    logic [8:0] got;
    forever begin
      @(negedge clk_ibex);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        match_byte(got);
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk_ibex);
      cycles++;
    end
    abort_run($sformatf("Timeout, the run did not finish within %0d cycles", timeout_cycles));
  end

  initial begin : stimulus
    logic [7:0] d;
    logic [7:0] b1;
    logic [7:0] b2;
    void'($urandom(32'h367a_e834));
    rst_n      = 1'b0;
    rx         = 2'b11;
    ref_status = '0;
    ref_wait   = 1'b0;
    ref_dst    = 1'b0;
    repeat (5) @(posedge clk_ibex);
    rst_n <= 1'b1;
    // Let the two-stage reset synchronizer release the core
    repeat (4) @(posedge clk_ibex);

    // Echo of eight random bytes on the console
    for (int i = 0; i < 8; i++) begin
      console_byte(nexus_ctrl_pkg::OP_ECHO, 1'b0);
      console_byte(rand_byte(), 1'b0);
    end
    wait_drain();
    settle();
    check_status(ref_status);

    // Forward to channel 1, channel 0 stays quiet
    for (int i = 0; i < 4; i++) begin
      console_byte(nexus_ctrl_pkg::OP_FWD, 1'b0);
      console_byte(rand_byte(), 1'b0);
    end
    wait_drain();
    settle();
    check_status(ref_status);

    // Plain bridging with a frame of space between bytes
    for (int i = 0; i < 3; i++) begin
      bridge_byte(rand_byte(), 1'b0, 1'b0);
      repeat (frame_cycles) @(posedge clk_ibex);
    end
    // Bridge byte arriving together with an echo command
    for (int i = 0; i < 3; i++) begin
      d  = rand_byte();
      b1 = rand_byte();
      fork
        begin
          console_byte(nexus_ctrl_pkg::OP_ECHO, 1'b0);
          console_byte(d, 1'b0);
        end
        bridge_byte(b1, 1'b0, 1'b0);
      join
      wait_drain();
    end
    settle();
    check_status(ref_status);

    // Halt, an echo that must be ignored, then clear
    console_byte(nexus_ctrl_pkg::OP_HALT, 1'b0);
    settle();
    check_status(ref_status);
    // Top bit set keeps the payload away from every opcode value
    d = rand_byte() | 8'h80;
    console_byte(nexus_ctrl_pkg::OP_ECHO, 1'b0);
    console_byte(d, 1'b0);
    settle();
    check_status(ref_status);
    clear_status();
    console_byte(nexus_ctrl_pkg::OP_ECHO, 1'b0);
    console_byte(rand_byte(), 1'b0);
    wait_drain();
    settle();
    check_status(ref_status);

    // Unknown opcode
    console_byte(rand_byte() | 8'h80, 1'b0);
    settle();
    check_status(ref_status);
    clear_status();

    // Low stop bit, console first and then the bridged port
    console_byte(rand_byte(), 1'b1);
    settle();
    check_status(ref_status);
    clear_status();
    bridge_byte(rand_byte(), 1'b1, 1'b0);
    settle();
    check_status(ref_status);
    clear_status();

    // The echo holds the FSM in ST_WAIT_DATA, so the second bridge byte finds the register full
    d  = rand_byte();
    b1 = rand_byte();
    b2 = rand_byte();
    fork
      begin
        console_byte(nexus_ctrl_pkg::OP_ECHO, 1'b0);
        console_byte(d, 1'b0);
      end
      begin
        bridge_byte(b1, 1'b0, 1'b0);
        bridge_byte(b2, 1'b0, 1'b1);
      end
    join
    wait_drain();
    settle();
    check_status(ref_status);
    clear_status();

    if (exp_q.size() == 0 && got_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("Run ended with serial bytes still waiting to be matched");
    end
  end

endmodule

`default_nettype wire

/* uart_rx.sv */
// Oversampling 8N1 serial receiver with a byte strobe and framing-error flag
`default_nettype none

`include "nexus_config.svh"

module uart_rx (
  input  wire logic                    clk_ibex,
  input  wire logic                    rst_n,
  input  wire logic                    tick_i,
  input  wire logic                    rx_i,
  output nexus_uart_pkg::uart_rx_evt_t evt_o
);

  localparam int unsigned cnt_w = $clog2(`NEXUS_OVS_RATE);
  // Half a bit after the falling edge lands in the middle of the start bit
  localparam logic [cnt_w-1:0] mid_tick  = cnt_w'(`NEXUS_OVS_RATE / 2 - 1);
  localparam logic [cnt_w-1:0] last_tick = cnt_w'(`NEXUS_OVS_RATE - 1);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_WAIT_HIGH
  } rx_state_e;

  rx_state_e        state_q;
  logic             rx_meta_q;
  logic             rx_sync_q;
  logic [cnt_w-1:0] tick_cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             evt_valid_q;
  logic             frame_err_q;
  logic             bit_end;
  logic             sample_data;
  logic             sample_stop;

  // Two-flop synchronizer, idle line is high
  always_ff @(posedge clk_ibex or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // Middle of a data or stop bit, counted from the confirmed start bit
  assign bit_end     = tick_i && (tick_cnt_q == last_tick);
  assign sample_data = (state_q == RX_DATA) && bit_end;
  assign sample_stop = (state_q == RX_STOP) && bit_end;

  always_ff @(posedge clk_ibex or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RX_IDLE;
      tick_cnt_q  <= '0;
      bit_idx_q   <= '0;
      evt_valid_q <= 1'b0;
    end else begin
      evt_valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          // Hunt for the falling edge of a start bit
          if (!rx_sync_q) begin
            state_q    <= RX_START;
            tick_cnt_q <= '0;
          end
        end
        RX_START: begin
          if (tick_i) begin
            if (tick_cnt_q == mid_tick) begin
              // A line that is high again at mid-bit was only a glitch
              tick_cnt_q <= '0;
              bit_idx_q  <= '0;
              state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
            end else begin
              tick_cnt_q <= tick_cnt_q + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            tick_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            // Strobe on the cycle after the stop sample
            // A low stop bit must go high before the next start is hunted
            evt_valid_q <= 1'b1;
            tick_cnt_q  <= '0;
            state_q     <= rx_sync_q ? RX_IDLE : RX_WAIT_HIGH;
          end else if (tick_i) begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end
        RX_WAIT_HIGH: begin
          if (rx_sync_q) begin
            state_q <= RX_IDLE;
          end
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // Data arrives LSB first, so it enters at the top and moves down
  always_ff @(posedge clk_ibex) begin
    if (sample_data) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
    if (sample_stop) begin
      frame_err_q <= !rx_sync_q;
    end
  end

  assign evt_o.valid     = evt_valid_q;
  assign evt_o.data      = shift_q;
  assign evt_o.frame_err = frame_err_q;

endmodule

`default_nettype wire

/* uart_tx.sv */
// Serial 8N1 transmitter with a single-cycle request and a busy level
`default_nettype none

`include "nexus_config.svh"

module uart_tx (
  input  wire logic                         clk_ibex,
  input  wire logic                         rst_n,
  input  wire logic                         tick_i,
  input  wire nexus_uart_pkg::uart_tx_req_t req_i,
  output logic                              tx_o,
  output logic                              busy_o
);

  localparam int unsigned cnt_w = $clog2(`NEXUS_OVS_RATE);
  localparam logic [cnt_w-1:0] last_tick = cnt_w'(`NEXUS_OVS_RATE - 1);

  // Frame is stop, data and start from MSB to LSB, and bit 0 is on the line
  logic [9:0]       frame_q;
  logic [cnt_w-1:0] tick_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             busy_q;

  always_ff @(posedge clk_ibex or negedge rst_n) begin
    if (!rst_n) begin
      // All ones keeps the line at the idle level
      frame_q    <= '1;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b0;
    end else if (!busy_q) begin
      if (req_i.valid) begin
        frame_q    <= {1'b1, req_i.data, 1'b0};
        tick_cnt_q <= '0;
        bit_cnt_q  <= '0;
        busy_q     <= 1'b1;
      end
    end else if (tick_i) begin
      if (tick_cnt_q == last_tick) begin
        // Next bit, ones fill in behind so the line returns high
        tick_cnt_q <= '0;
        frame_q    <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9) begin
          // The stop bit has just ended
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
    end
  end

  assign tx_o   = frame_q[0];
  assign busy_o = busy_q;

endmodule

`default_nettype wire
